/* verif/rtcCtrl_stimulus.txt */
// op_field_arg_expect in hex, op 1 load (arg is value), 2 step, 3 check
// step arg: bit 0 up, bit 1 down, bit 4 second edge while pending
1_0_59_00
1_1_30_00
1_2_00_00
1_3_01_00
1_4_12_00
1_5_99_00
3_0_00_59
3_1_00_30
3_2_00_00
3_3_00_01
3_4_00_12
3_5_00_99
2_0_01_00 // seconds 59 up wraps
2_0_01_01
2_4_01_01 // month 12 up wraps
2_1_02_29 // minutes borrow
2_3_12_31 // day 01 down wraps, extra edge
2_2_12_23 // hours 00 down wraps, extra edge
2_5_01_00 // year 99 up wraps
2_1_03_30 // both switches, up wins

/* rtcCtrl.f */
+incdir+src
src/rtcCtrlPkg.sv
src/rtcBusPort.sv
src/rtcSequencer.sv
src/timeShadow.sv
src/userEditor.sv
src/rtcCtrlTop.sv
verif/rtcChipModel.sv
verif/rtcCtrlTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module rtcCtrlTb -f rtcCtrl.f -o simRtcCtrl
./obj_dir/simRtcCtrl > sim.log 2>&1
cat sim.log

if grep -qx "PASS: all tests" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, see sim.log"
exit 1

/* verif/rtcCtrlTb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rtcCtrl_config.svh"

module rtcCtrlTb;
	import rtcCtrlPkg::*;

	localparam int MaxRecords = 64;
	localparam busAddr_t LastAddr = `RTC_FIELD_BASE + 8'(`RTC_NUM_FIELDS - 1);

	logic        clk;
	logic        rst;
	fieldIdx_t   fieldSel;
	logic        stepUp;
	logic        stepDown;
	fieldIdx_t   readIdx;
	bcd_t        readData;
	logic        busAs;
	logic        busCs;
	logic        busRd;
	logic        busWr;
	logic [7:0]  busDataOut;
	logic        busDataOe;
	bcd_t        busDataIn;
	logic        loadEn;
	busAddr_t    loadAddr;
	bcd_t        loadData;
	busAddr_t    peekAddr;
	bcd_t        peekData;
	busAddr_t    chipAddr;
	logic [15:0] violations;

	logic [23:0] stim [MaxRecords];
	int   errors     = 0;
	int   cycles     = 0;
	int   cycleLimit = 0;
	int   writeCnt   = 0;
	int   roundCnt   = 0;
	logic wrLow      = 1'b0;
	logic rdLow      = 1'b0;
	bit   dirty      = 1'b0;

	rtcCtrlTop u_dut (
		.clk(clk), .rst(rst), .busDataIn(busDataIn),
		.fieldSel(fieldSel), .stepUp(stepUp), .stepDown(stepDown), .readIdx(readIdx),
		.busAs(busAs), .busCs(busCs), .busRd(busRd), .busWr(busWr),
		.busDataOut(busDataOut), .busDataOe(busDataOe), .readData(readData)
	);

	rtcChipModel u_chip (
		.clk(clk), .rst(rst),
		.busAs(busAs), .busCs(busCs), .busRd(busRd), .busWr(busWr),
		.busDataOut(busDataOut), .busDataOe(busDataOe), .busDataIn(busDataIn),
		.loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.peekAddr(peekAddr), .peekData(peekData),
		.regAddr(chipAddr), .violations(violations)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// bus monitor and watchdog
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		cycles <= cycles + 1;
		wrLow  <= !busWr;
		rdLow  <= !busRd;
		if (wrLow && busWr) begin
			writeCnt <= writeCnt + 1;
		end
		// a round ends when the year read strobe rises
		if (rdLow && busRd && chipAddr == LastAddr) begin
			roundCnt <= roundCnt + 1;
		end
		if (cycleLimit > 0 && cycles >= cycleLimit) begin
			$display("timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic checkBcd(input bcd_t got, input bcd_t expVal, input string what);
		if (got !== expVal) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, expVal);
			errors++;
		end
	endtask

	task automatic checkFlag(input logic got, input logic expVal, input string what);
		if (got !== expVal) begin
			$display("error at %0t ns: %s is %b, expected %b", $time, what, got, expVal);
			errors++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// access helpers
	//////////////////////////////////////////////////////////////////////

	task automatic readShadow(input fieldIdx_t f, output bcd_t v);
		@(posedge clk);
		readIdx <= f;
		@(negedge clk);
		v = readData;
	endtask

	task automatic peekModel(input busAddr_t a, output bcd_t v);
		@(posedge clk);
		peekAddr <= a;
		@(negedge clk);
		v = peekData;
	endtask

	// returns once the shadow holds the last round's values
	task automatic waitRounds(input int n);
		int target;
		target = roundCnt + n;
		while (roundCnt < target) begin
			@(negedge clk);
		end
		repeat (3) @(negedge clk);
	endtask

	task automatic waitWrites(input int n);
		while (writeCnt < n) begin
			@(negedge clk);
		end
	endtask

	task automatic pressSwitches(input fieldIdx_t f, input logic [7:0] arg);
		@(posedge clk);
		fieldSel <= f;
		stepUp   <= arg[0];
		stepDown <= arg[1];
		repeat (3) @(posedge clk);
		stepUp   <= 1'b0;
		stepDown <= 1'b0;
		repeat (3) @(posedge clk);
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus operations
	//////////////////////////////////////////////////////////////////////

	task automatic loadField(input fieldIdx_t f, input bcd_t v);
		@(posedge clk);
		loadEn   <= 1'b1;
		loadAddr <= `RTC_FIELD_BASE + busAddr_t'(f);
		loadData <= v;
		@(posedge clk);
		loadEn   <= 1'b0;
		dirty = 1'b1;
	endtask

	task automatic checkField(input fieldIdx_t f, input bcd_t expVal);
		bcd_t got;
		if (dirty) begin
			waitRounds(2);
			dirty = 1'b0;
		end
		readShadow(f, got);
		checkBcd(got, expVal, $sformatf("display read of field %0d", f));
		peekModel(`RTC_FIELD_BASE + busAddr_t'(f), got);
		checkBcd(got, expVal, $sformatf("chip register of field %0d", f));
	endtask

	// arg bit 0 steps up and bit 1 steps down
	// bit 4 adds an edge of the other switch while the request is pending
	task automatic stepField(input fieldIdx_t f, input logic [7:0] arg, input bcd_t expVal);
		int   wrBefore;
		bcd_t got;
		waitRounds(dirty ? 2 : 1);
		dirty = 1'b0;
		wrBefore = writeCnt;
		pressSwitches(f, arg);
		if (arg[4]) begin
			pressSwitches(f, {arg[7:2], arg[0], arg[1]});
		end
		waitWrites(wrBefore + 1);
		peekModel(`RTC_FIELD_BASE + busAddr_t'(f), got);
		checkBcd(got, expVal, $sformatf("chip register of field %0d after step", f));
		waitRounds(1);
		readShadow(f, got);
		checkBcd(got, expVal, $sformatf("shadow of field %0d after step", f));
		if (arg[4]) begin
			waitRounds(1);
			checkFlag(writeCnt == wrBefore + 1, 1'b1, "single write for repeated edge");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int          nRec;
		logic [23:0] rec;
		bcd_t        got;
		rst      <= 1'b1;
		fieldSel <= '0;
		stepUp   <= 1'b0;
		stepDown <= 1'b0;
		readIdx  <= '0;
		loadEn   <= 1'b0;
		loadAddr <= '0;
		loadData <= '0;
		peekAddr <= '0;
		for (int i = 0; i < MaxRecords; i++) begin
			stim[6'(i)] = '0;
		end
		$readmemh("verif/rtcCtrl_stimulus.txt", stim);
		nRec = 0;
		while (nRec < MaxRecords && stim[6'(nRec)][23:20] != 4'h0) begin
			nRec++;
		end
		if (nRec == 0) begin
			$display("the stimulus file gave no records");
			errors++;
		end
		// two rounds plus an edit per record
		cycleLimit = nRec * 84 + 200;

		repeat (2) @(posedge clk);
		@(negedge clk);
		checkFlag(busCs, 1'b1, "busCs in reset");
		checkFlag(busRd, 1'b1, "busRd in reset");
		checkFlag(busWr, 1'b1, "busWr in reset");
		checkFlag(busAs, 1'b0, "busAs in reset");
		checkFlag(busDataOe, 1'b0, "busDataOe in reset");
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		// first edge with reset low only raises the start pulse
		@(posedge clk);
		@(negedge clk);
		checkFlag(busCs, 1'b1, "busCs after reset");
		checkFlag(busRd, 1'b1, "busRd after reset");
		checkFlag(busWr, 1'b1, "busWr after reset");
		checkFlag(busAs, 1'b0, "busAs after reset");
		checkFlag(busDataOe, 1'b0, "busDataOe after reset");
		for (int i = 0; i < `RTC_NUM_FIELDS; i++) begin
			readShadow(3'(i), got);
			checkBcd(got, 8'h00, $sformatf("shadow field %0d after reset", i));
		end

		// init writes control then status
		waitWrites(2);
		peekModel(`RTC_CTRL_ADDR, got);
		checkBcd(got, `RTC_CTRL_INIT, "control register after init");
		peekModel(`RTC_STAT_ADDR, got);
		checkBcd(got, `RTC_STAT_INIT, "status register after init");

		for (int n = 0; n < nRec; n++) begin
			rec = stim[6'(n)];
			case (rec[23:20])
				4'h1: loadField(rec[18:16], rec[15:8]);
				4'h2: stepField(rec[18:16], rec[15:8], rec[7:0]);
				4'h3: checkField(rec[18:16], rec[7:0]);
				default: begin
					$display("stimulus record %0d has an unknown operation %h", n, rec[23:20]);
					errors++;
				end
			endcase
		end

		if (violations != 16'd0) begin
			$display("the chip model saw %0d bus protocol violations", violations);
			errors++;
		end
		$display("errors: %0d  protocol violations: %0d  cycles: %0d", errors, violations, cycles);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/rtcChipModel.sv */
`timescale 1ns/100ps
`default_nettype none

module rtcChipModel (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       busAs,
	input  wire                       busCs,
	input  wire                       busRd,
	input  wire                       busWr,
	input  wire [7:0]                 busDataOut,
	input  wire                       busDataOe,
	output rtcCtrlPkg::bcd_t          busDataIn,
	input  wire                       loadEn,
	input  wire rtcCtrlPkg::busAddr_t loadAddr,
	input  wire rtcCtrlPkg::bcd_t     loadData,
	input  wire rtcCtrlPkg::busAddr_t peekAddr,
	output rtcCtrlPkg::bcd_t          peekData,
	output rtcCtrlPkg::busAddr_t      regAddr,
	output logic [15:0]               violations
);
	import rtcCtrlPkg::*;

	bcd_t regs [256];
	logic badCycle;

	// both strobes, a strobe without chip select, or an undriven write
	assign badCycle = (!busRd && !busWr)
		|| (busCs && (busAs || !busRd || !busWr))
		|| (!busCs && !busWr && !busDataOe);

	always_ff @(posedge clk) begin
		if (rst) begin
			// every register starts from its own address pattern
			for (int i = 0; i < 256; i++) begin
				regs[8'(i)] <= 8'(i) ^ 8'h5A;
			end
			regAddr    <= '0;
			violations <= '0;
		end else begin
			if (loadEn) begin
				regs[loadAddr] <= loadData;
			end else if (!busCs && !busWr) begin
				regs[regAddr] <= busDataOut;
			end
			// address latched while the strobe is high
			if (!busCs && busAs) begin
				regAddr <= busDataOut;
			end
			if (badCycle) begin
				violations <= violations + 16'd1;
			end
		end
	end

	// chip drives the lines only while read strobe and select are low
	assign busDataIn = (!busCs && !busRd) ? regs[regAddr] : 8'hFF;
	assign peekData  = regs[peekAddr];

endmodule

`default_nettype wire

/* src/rtcCtrlTop.sv */
`timescale 1ns/100ps
`default_nettype none

module rtcCtrlTop (
	input  wire                        clk,
	input  wire                        rst,
	input  wire rtcCtrlPkg::bcd_t      busDataIn,
	input  wire rtcCtrlPkg::fieldIdx_t fieldSel,
	input  wire                        stepUp,
	input  wire                        stepDown,
	input  wire rtcCtrlPkg::fieldIdx_t readIdx,
	output wire                        busAs,
	output wire                        busCs,
	output wire                        busRd,
	output wire                        busWr,
	output wire [7:0]                  busDataOut,
	output wire                        busDataOe,
	output wire rtcCtrlPkg::bcd_t      readData
);
	import rtcCtrlPkg::*;

	// sequencer to bus port
	wire           xferStart;
	wire busOp_t   xferOp;
	wire busAddr_t xferAddr;
	wire bcd_t     xferData;
	wire           xferDone;
	wire bcd_t     xferRdData;

	// sequencer to shadow
	wire            shadowWe;
	wire fieldIdx_t shadowWrIdx;
	wire bcd_t      shadowWrData;

	// editor side
	wire            editReq;
	wire            editAck;
	wire fieldIdx_t editIdx;
	wire bcd_t      editData;
	wire fieldIdx_t edRdIdx;
	wire bcd_t      edRdData;

	//////////////////////////////////////////////////////////////////////
	// transaction producer and pin consumer
	//////////////////////////////////////////////////////////////////////

	rtcSequencer u_seq (
		.clk(clk), .rst(rst),
		.xferDone(xferDone), .xferRdData(xferRdData),
		.editReq(editReq), .editIdx(editIdx), .editData(editData),
		.xferStart(xferStart), .xferOp(xferOp), .xferAddr(xferAddr), .xferData(xferData),
		.shadowWe(shadowWe), .shadowWrIdx(shadowWrIdx), .shadowWrData(shadowWrData),
		.editAck(editAck)
	);

	rtcBusPort u_bus (
		.clk(clk), .rst(rst),
		.xferStart(xferStart), .xferOp(xferOp), .xferAddr(xferAddr), .xferData(xferData),
		.busDataIn(busDataIn),
		.xferDone(xferDone), .xferRdData(xferRdData),
		.busAs(busAs), .busCs(busCs), .busRd(busRd), .busWr(busWr),
		.busDataOut(busDataOut), .busDataOe(busDataOe)
	);

	//////////////////////////////////////////////////////////////////////
	// shadow copy and user stepping
	//////////////////////////////////////////////////////////////////////

	// port A for the display, port B for the editor
	timeShadow u_shadow (
		.clk(clk), .rst(rst),
		.we(shadowWe), .wrIdx(shadowWrIdx), .wrData(shadowWrData),
		.rdIdxA(readIdx), .rdIdxB(edRdIdx),
		.rdDataA(readData), .rdDataB(edRdData)
	);

	userEditor u_edit (
		.clk(clk), .rst(rst),
		.fieldSel(fieldSel), .stepUp(stepUp), .stepDown(stepDown),
		.curData(edRdData), .editAck(editAck),
		.curIdx(edRdIdx), .editReq(editReq), .editIdx(editIdx), .editData(editData)
	);

endmodule

`default_nettype wire

/* src/userEditor.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rtcCtrl_config.svh"

module userEditor (
	input  wire                        clk,
	input  wire                        rst,
	input  wire rtcCtrlPkg::fieldIdx_t fieldSel,
	input  wire                        stepUp,
	input  wire                        stepDown,
	input  wire rtcCtrlPkg::bcd_t      curData,
	input  wire                        editAck,
	output rtcCtrlPkg::fieldIdx_t      curIdx,
	output logic                       editReq,
	output rtcCtrlPkg::fieldIdx_t      editIdx,
	output rtcCtrlPkg::bcd_t           editData
);
	import rtcCtrlPkg::*;

	localparam fieldIdx_t FieldHours = 3'd2;
	localparam fieldIdx_t FieldDay   = 3'd3;
	localparam fieldIdx_t FieldMonth = 3'd4;
	localparam fieldIdx_t FieldYear  = 3'd5;

	logic upSync;
	logic upPrev;
	logic downSync;
	logic downPrev;
	logic upEdge;
	logic downEdge;
	logic validSel;

	function automatic bcd_t fieldMin(input fieldIdx_t idx);
		return (idx == FieldDay || idx == FieldMonth) ? 8'h01 : 8'h00;
	endfunction

	function automatic bcd_t fieldMax(input fieldIdx_t idx);
		bcd_t lim;
		case (idx)
			FieldHours: lim = 8'h23;
			FieldDay:   lim = 8'h31;
			FieldMonth: lim = 8'h12;
			FieldYear:  lim = 8'h99;
			default:    lim = 8'h59;
		endcase
		return lim;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// BCD step with wrap
	//////////////////////////////////////////////////////////////////////

	function automatic bcd_t bcdUp(input bcd_t v, input fieldIdx_t idx);
		bcd_t r;
		if (v >= fieldMax(idx)) begin
			r = fieldMin(idx);
		end else if (v[3:0] >= 4'd9) begin
			r = {v[7:4] + 4'd1, 4'd0};
		end else begin
			r = {v[7:4], v[3:0] + 4'd1};
		end
		return r;
	endfunction

	function automatic bcd_t bcdDown(input bcd_t v, input fieldIdx_t idx);
		bcd_t r;
		if (v <= fieldMin(idx)) begin
			r = fieldMax(idx);
		end else if (v[3:0] == 4'd0) begin
			r = {v[7:4] - 4'd1, 4'd9};
		end else begin
			r = {v[7:4], v[3:0] - 4'd1};
		end
		return r;
	endfunction

	// shadow is read at the selected field
	assign curIdx   = fieldSel;
	assign validSel = (int'(fieldSel) < `RTC_NUM_FIELDS);
	assign upEdge   = upSync && !upPrev;
	assign downEdge = downSync && !downPrev;

	always_ff @(posedge clk) begin
		if (rst) begin
			upSync   <= 1'b0;
			upPrev   <= 1'b0;
			downSync <= 1'b0;
			downPrev <= 1'b0;
			editReq  <= 1'b0;
		end else begin
			upSync   <= stepUp;
			upPrev   <= upSync;
			downSync <= stepDown;
			downPrev <= downSync;
			if (editAck) begin
				editReq <= 1'b0;
			end else if (!editReq && validSel && (upEdge || downEdge)) begin
				editReq <= 1'b1;
			end
		end
	end

	// edges seen while a request is pending are dropped
	always_ff @(posedge clk) begin
		if (!editReq && validSel && (upEdge || downEdge)) begin
			editIdx  <= fieldSel;
			// up wins when both rise together
			editData <= upEdge ? bcdUp(curData, fieldSel) : bcdDown(curData, fieldSel);
		end
	end

endmodule

`default_nettype wire

/* src/timeShadow.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rtcCtrl_config.svh"

module timeShadow (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        we,
	input  wire rtcCtrlPkg::fieldIdx_t wrIdx,
	input  wire rtcCtrlPkg::bcd_t      wrData,
	input  wire rtcCtrlPkg::fieldIdx_t rdIdxA,
	input  wire rtcCtrlPkg::fieldIdx_t rdIdxB,
	output rtcCtrlPkg::bcd_t           rdDataA,
	output rtcCtrlPkg::bcd_t           rdDataB
);
	import rtcCtrlPkg::*;

	localparam int NumFields = `RTC_NUM_FIELDS;

	bcd_t fields [NumFields];

	// one entry per time field and all zero until the first poll round
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NumFields; i++) begin
				fields[i] <= '0;
			end
		end else if (we && int'(wrIdx) < NumFields) begin
			fields[wrIdx] <= wrData;
		end
	end

	// indices 6 and 7 have no field behind them
	assign rdDataA = (int'(rdIdxA) < NumFields) ? fields[rdIdxA] : '0;
	assign rdDataB = (int'(rdIdxB) < NumFields) ? fields[rdIdxB] : '0;

endmodule

`default_nettype wire

/* src/rtcSequencer.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rtcCtrl_config.svh"

module rtcSequencer (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        xferDone,
	input  wire rtcCtrlPkg::bcd_t      xferRdData,
	input  wire                        editReq,
	input  wire rtcCtrlPkg::fieldIdx_t editIdx,
	input  wire rtcCtrlPkg::bcd_t      editData,
	output logic                       xferStart,
	output rtcCtrlPkg::busOp_t         xferOp,
	output rtcCtrlPkg::busAddr_t       xferAddr,
	output rtcCtrlPkg::bcd_t           xferData,
	output logic                       shadowWe,
	output rtcCtrlPkg::fieldIdx_t      shadowWrIdx,
	output rtcCtrlPkg::bcd_t           shadowWrData,
	output logic                       editAck
);
	import rtcCtrlPkg::*;

	typedef enum logic [1:0] {
		stInitCtrl,
		stInitStat,
		stPoll,
		stEdit
	} seqState_t;

	localparam fieldIdx_t LastField = fieldIdx_t'(`RTC_NUM_FIELDS - 1);

	// state names the transaction in flight, fieldCnt the field being read
	seqState_t state;
	seqState_t nextState;
	fieldIdx_t fieldCnt;
	fieldIdx_t nextCnt;
	logic      started;
	logic      launch;
	busOp_t    txOp;
	busAddr_t  txAddr;
	bcd_t      txData;

	//////////////////////////////////////////////////////////////////////
	// scheduling
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		nextState = state;
		nextCnt   = fieldCnt;
		if (xferDone) begin
			case (state)
				stInitCtrl: nextState = stInitStat;
				stInitStat: begin
					nextState = stPoll;
					nextCnt   = '0;
				end
				stPoll: begin
					if (fieldCnt == LastField) begin
						// squeeze in a pending edit at the end of a round
						nextCnt   = '0;
						nextState = editReq ? stEdit : stPoll;
					end else begin
						nextCnt = fieldCnt + fieldIdx_t'(1);
					end
				end
				default: begin
					nextState = stPoll;
					nextCnt   = '0;
				end
			endcase
		end
	end

	// first launch after reset and then one on every done
	assign launch = !started || xferDone;

	//////////////////////////////////////////////////////////////////////
	// transaction contents
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		txOp   = opRead;
		txAddr = `RTC_FIELD_BASE + busAddr_t'(nextCnt);
		txData = '0;
		case (nextState)
			stInitCtrl: begin
				txOp   = opWrite;
				txAddr = `RTC_CTRL_ADDR;
				txData = `RTC_CTRL_INIT;
			end
			stInitStat: begin
				txOp   = opWrite;
				txAddr = `RTC_STAT_ADDR;
				txData = `RTC_STAT_INIT;
			end
			stEdit: begin
				txOp   = opWrite;
				txAddr = `RTC_FIELD_BASE + busAddr_t'(editIdx);
				txData = editData;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= stInitCtrl;
			fieldCnt  <= '0;
			started   <= 1'b0;
			xferStart <= 1'b0;
			shadowWe  <= 1'b0;
		end else begin
			state     <= nextState;
			fieldCnt  <= nextCnt;
			xferStart <= launch;
			if (launch) begin
				started <= 1'b1;
			end
			// poll result lands in the shadow one cycle after done
			shadowWe <= xferDone && (state == stPoll);
		end
	end

	// held stable until the next launch
	always_ff @(posedge clk) begin
		if (launch) begin
			xferOp   <= txOp;
			xferAddr <= txAddr;
			xferData <= txData;
		end
		shadowWrIdx  <= fieldCnt;
		shadowWrData <= xferRdData;
	end

	assign editAck = xferDone && (state == stEdit);

endmodule

`default_nettype wire

/* src/rtcBusPort.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rtcCtrl_config.svh"

module rtcBusPort (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       xferStart,
	input  wire rtcCtrlPkg::busOp_t   xferOp,
	input  wire rtcCtrlPkg::busAddr_t xferAddr,
	input  wire rtcCtrlPkg::bcd_t     xferData,
	input  wire rtcCtrlPkg::bcd_t     busDataIn,
	output logic                      xferDone,
	output rtcCtrlPkg::bcd_t          xferRdData,
	output logic                      busAs,
	output logic                      busCs,
	output logic                      busRd,
	output logic                      busWr,
	output logic [7:0]                busDataOut,
	output logic                      busDataOe
);
	import rtcCtrlPkg::*;

	typedef enum logic [1:0] {
		phIdle,
		phAddr,
		phData,
		phRecov
	} busPhase_t;

	busPhase_t  phase;
	logic [2:0] phaseCnt;
	logic       lastCycle;

	assign lastCycle = (phaseCnt == 3'(`BUS_PHASE_CYCLES - 1));

	//////////////////////////////////////////////////////////////////////
	// phase sequencing
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			phase    <= phIdle;
			phaseCnt <= '0;
		end else if (phase == phIdle) begin
			phaseCnt <= '0;
			if (xferStart) begin
				phase <= phAddr;
			end
		end else if (lastCycle) begin
			phaseCnt <= '0;
			case (phase)
				phAddr:  phase <= phData;
				phData:  phase <= phRecov;
				default: phase <= phIdle;
			endcase
		end else begin
			phaseCnt <= phaseCnt + 3'd1;
		end
	end

	// read byte is taken on the last data cycle while the strobe is still low
	always_ff @(posedge clk) begin
		if (phase == phData && lastCycle && xferOp == opRead) begin
			xferRdData <= busDataIn;
		end
	end

	assign xferDone = (phase == phRecov) && lastCycle;

	//////////////////////////////////////////////////////////////////////
	// pin decode
	//////////////////////////////////////////////////////////////////////

	assign busAs = (phase == phAddr);
	assign busCs = !(phase == phAddr || phase == phData);
	assign busRd = !(phase == phData && xferOp == opRead);
	assign busWr = !(phase == phData && xferOp == opWrite);

	// address and write data share the lines
	always_comb begin
		busDataOut = '0;
		busDataOe  = 1'b0;
		if (phase == phAddr) begin
			busDataOut = xferAddr;
			busDataOe  = 1'b1;
		end else if (phase == phData && xferOp == opWrite) begin
			busDataOut = xferData;
			busDataOe  = 1'b1;
		end
	end

endmodule

`default_nettype wire

/* src/rtcCtrlPkg.sv */
`default_nettype none

package rtcCtrlPkg;

	//////////////////////////////////////////////////////////////////////
	// time field and data types
	//////////////////////////////////////////////////////////////////////

	// 0 sec, 1 min, 2 hours, 3 day, 4 month, 5 year
	typedef logic [2:0] fieldIdx_t;

	// two packed BCD digits with the tens in the upper nibble
	typedef logic [7:0] bcd_t;

	//////////////////////////////////////////////////////////////////////
	// bus types
	//////////////////////////////////////////////////////////////////////

	// register address as sent in the address phase
	typedef logic [7:0] busAddr_t;

	// direction of one bus transaction
	typedef enum logic {
		opRead  = 1'b0,
		opWrite = 1'b1
	} busOp_t;

endpackage

`default_nettype wire

/* src/rtcCtrl_config.svh */
`ifndef RTC_CTRL_CONFIG_SVH
`define RTC_CTRL_CONFIG_SVH

// chip register map
`define RTC_CTRL_ADDR 8'h00
`define RTC_STAT_ADDR 8'h01
// seconds register with minutes through year following at +1 .. +5
`define RTC_FIELD_BASE 8'h21

// start-up values written once after reset
`define RTC_CTRL_INIT 8'h10
// writing zero clears all pending status flags
`define RTC_STAT_INIT 8'h00

// seconds, minutes, hours, day, month, year
`define RTC_NUM_FIELDS 6

// clock cycles spent in each of the address, data and recovery phases
`define BUS_PHASE_CYCLES 2

`endif
